// ==== filelist.f ====
logic/xbar_pkg.sv
logic/xbar_addr_decode.sv
logic/xbar_req_demux.sv
logic/obi_sram_bank.sv
logic/xbar_rsp_collect.sv
logic/xbar_bank_subsystem.sv
bench/tb_xbar_bank_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the crossbar testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_xbar_bank_subsystem

rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -Wno-fatal \
  --top-module "$TOP" -f filelist.f -o "V$TOP"
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

./obj_dir/"V$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "TEST RESULT: PASS" "$LOG"; then
  echo "Simulation passed"
  exit 0
else
  echo "Pass line not found in $LOG"
  exit 1
fi

// ==== bench/xbar_cases.txt ====
// gap we be addr wdata exp_rdata, all hex, one transaction per line
// gap counts idle cycles before req_i, writes expect zero rdata
2 1 F 00010000 11223344 00000000
0 1 3 00010000 AABBCCDD 00000000
0 0 F 00010000 00000000 1122CCDD
1 1 F 0001000C 01020304 00000000
0 1 C 0001000C F0E0D0C0 00000000
0 1 5 0001000C 99887766 00000000
0 0 F 0001000C 00000000 F0880366
1 1 F 0001100C 1111AAAA 00000000
0 1 F 00012008 2222BBBB 00000000
0 1 F 00013004 3333CCCC 00000000
0 1 F 00010010 4444DDDD 00000000
2 0 F 0001100C 00000000 1111AAAA
0 0 F 00012008 00000000 2222BBBB
0 0 F 00013004 00000000 3333CCCC
0 0 F 00010010 00000000 4444DDDD
0 0 F 00010000 00000000 1122CCDD
3 1 F 00050014 5A5A0005 00000000
0 1 F ABCDE018 C0DE0006 00000000
0 1 C 77777018 12340000 00000000
1 0 F 00012014 00000000 5A5A0005
0 0 F 00012018 00000000 12340006
0 0 F 00012008 00000000 2222BBBB
0 0 F 000FF014 00000000 5A5A0005
2 1 F 00013000 DEAD0001 00000000
0 0 F 00013000 00000000 DEAD0001
0 0 F 00013004 00000000 3333CCCC
0 0 F 00013000 00000000 DEAD0001
0 1 1 00013000 000000FF 00000000
0 0 F 00013000 00000000 DEAD00FF

// ==== bench/tb_xbar_bank_subsystem.sv ====
`timescale 1ns/100ps

module tb_xbar_bank_subsystem;

  localparam int NUM_CASES   = 29;
  localparam int CASE_COLS   = 6;
  localparam int CYC_PER_CASE = 12;
  localparam int RESET_CYC   = 16;

  // Column order in the cases file
  localparam int COL_GAP   = 0;
  localparam int COL_WE    = 1;
  localparam int COL_BE    = 2;
  localparam int COL_ADDR  = 3;
  localparam int COL_WDATA = 4;
  localparam int COL_EXP   = 5;

  logic                                clk_i;
  logic                                reset_i;
  logic [xbar_pkg::BANK_IDX_W-1:0]     default_idx_i;
  logic                                req_i;
  logic                                we_i;
  logic [xbar_pkg::BE_W-1:0]           be_i;
  logic [xbar_pkg::ADDR_W-1:0]         addr_i;
  logic [xbar_pkg::DATA_W-1:0]         wdata_i;
  logic                                gnt_o;
  logic                                rvalid_o;
  logic [xbar_pkg::DATA_W-1:0]         rdata_o;

  // Six words per transaction, flat
  logic [31:0] case_words [NUM_CASES*CASE_COLS];
  int          grant_cycle [NUM_CASES];
  int          grant_count;
  int          resp_count;
  int          cycle_no;
  int          run_cycles;
  int          timeout_limit;
  int          lat;

  xbar_bank_subsystem dut_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .default_idx_i (default_idx_i),
    .req_i         (req_i),
    .we_i          (we_i),
    .be_i          (be_i),
    .addr_i        (addr_i),
    .wdata_i       (wdata_i),
    .gnt_o         (gnt_o),
    .rvalid_o      (rvalid_o),
    .rdata_o       (rdata_o)
  );

  always #20 clk_i = ~clk_i;

  function automatic logic [31:0] case_field(input int k, input int col);
    return case_words[k*CASE_COLS + col];
  endfunction

  // Bank latency floor, 1 plus word index bits 1:0
  function automatic int min_latency(input int k);
    logic [31:0] a;
    a = case_field(k, COL_ADDR);
    return 1 + int'(a[3:2]);
  endfunction

  task automatic abort_run();
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  // --------------------
  // Request driver
  // --------------------
  // Starts 2 ns after a rising edge, holds until gnt_o seen
  task automatic issue_case(input int k);
    logic [31:0] gap;
    logic [31:0] ctl;
    logic [31:0] be_word;
    logic        granted;
    gap     = case_field(k, COL_GAP);
    ctl     = case_field(k, COL_WE);
    be_word = case_field(k, COL_BE);
    if (gap != 0) begin
      req_i = 1'b0;
      repeat (gap) begin
        @(posedge clk_i);
        #2;
      end
    end
    req_i   = 1'b1;
    we_i    = ctl[0];
    be_i    = be_word[xbar_pkg::BE_W-1:0];
    addr_i  = case_field(k, COL_ADDR);
    wdata_i = case_field(k, COL_WDATA);
    granted = 1'b0;
    while (!granted) begin
      // Mid-cycle sample, inputs settled
      @(negedge clk_i);
      granted = gnt_o;
      @(posedge clk_i);
      #2;
    end
  endtask

  // --------------------
  // Response monitor
  // --------------------
  always @(negedge clk_i) begin
    cycle_no = cycle_no + 1;
    assert (!$isunknown(rvalid_o)) else begin
      $display("rvalid_o is unknown at cycle %0d", cycle_no);
      abort_run();
    end
    if (rvalid_o) begin
      // Nothing may come back before its own grant
      assert (resp_count < grant_count) else begin
        $display("Response seen with no request outstanding at cycle %0d", cycle_no);
        abort_run();
      end
      lat = cycle_no - grant_cycle[resp_count];
      assert (lat >= min_latency(resp_count)) else begin
        $display("Response to case %0d came after %0d cycles, too early", resp_count, lat);
        abort_run();
      end
      assert (rdata_o === case_field(resp_count, COL_EXP)) else begin
        $display("MISMATCH rdata_o case %0d: got 0x%08h expected 0x%08h",
                 resp_count, rdata_o, case_field(resp_count, COL_EXP));
        abort_run();
      end
      resp_count = resp_count + 1;
    end
    // Grant takes effect at the coming edge
    if (!reset_i && req_i && gnt_o && grant_count < NUM_CASES) begin
      grant_cycle[grant_count] = cycle_no;
      grant_count = grant_count + 1;
    end
  end

  // Run length guard
  always @(posedge clk_i) begin
    if (!reset_i) begin
      run_cycles = run_cycles + 1;
      if (run_cycles > timeout_limit) begin
        $display("Timeout after %0d cycles with %0d of %0d responses received",
                 run_cycles, resp_count, NUM_CASES);
        abort_run();
      end
    end
  end

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    clk_i         = 1'b0;
    reset_i       = 1'b1;
    default_idx_i = 2'd2;
    req_i         = 1'b0;
    we_i          = 1'b0;
    be_i          = '0;
    addr_i        = '0;
    wdata_i       = '0;
    grant_count   = 0;
    resp_count    = 0;
    cycle_no      = 0;
    run_cycles    = 0;
    // All ones marks words the file never filled
    for (int i = 0; i < NUM_CASES*CASE_COLS; i++) begin
      case_words[i] = '1;
    end
    $readmemh("bench/xbar_cases.txt", case_words);
    timeout_limit = NUM_CASES * CYC_PER_CASE;
    for (int k = 0; k < NUM_CASES; k++) begin
      assert (case_field(k, COL_WE) <= 1) else begin
        $display("Cases file is short or malformed at transaction %0d", k);
        abort_run();
      end
      timeout_limit = timeout_limit + int'(case_field(k, COL_GAP));
    end

    repeat (RESET_CYC) @(posedge clk_i);
    #2;
    reset_i = 1'b0;

    for (int k = 0; k < NUM_CASES; k++) begin
      issue_case(k);
    end
    req_i = 1'b0;

    wait (resp_count == NUM_CASES);
    // Quiet tail, a stray extra response shows up here
    repeat (8) @(negedge clk_i);
    // Every bank idle and the order queue empty, so the port is ready again
    assert (gnt_o === 1'b1) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      $display("MISMATCH gnt_o after drain: got 0x%0h expected 0x1", gnt_o);
      abort_run();
    end
  end

endmodule

// ==== logic/xbar_bank_subsystem.sv ====
`timescale 1ns/100ps

module xbar_bank_subsystem (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  // Bank for addresses outside the map
  input  logic [xbar_pkg::BANK_IDX_W-1:0]      default_idx_i,
  // Master port
  input  logic                                 req_i,
  input  logic                                 we_i,
  input  logic [xbar_pkg::BE_W-1:0]            be_i,
  input  logic [xbar_pkg::ADDR_W-1:0]          addr_i,
  input  logic [xbar_pkg::DATA_W-1:0]          wdata_i,
  output logic                                 gnt_o,
  output logic                                 rvalid_o,
  output logic [xbar_pkg::DATA_W-1:0]          rdata_o
);

  // --------------------
  // Demux to banks
  // --------------------
  logic [xbar_pkg::NUM_BANKS-1:0]                          bank_req;
  logic                                                    bank_we;
  logic [xbar_pkg::BE_W-1:0]                               bank_be;
  logic [xbar_pkg::ADDR_W-1:0]                             bank_addr;
  logic [xbar_pkg::DATA_W-1:0]                             bank_wdata;
  logic [xbar_pkg::NUM_BANKS-1:0]                          bank_gnt;

  // Banks to collector
  logic [xbar_pkg::NUM_BANKS-1:0]                          bank_rvalid;
  logic [xbar_pkg::NUM_BANKS-1:0][xbar_pkg::DATA_W-1:0]    bank_rdata;
  logic [xbar_pkg::NUM_BANKS-1:0]                          bank_take;

  // Order queue handshake
  logic                                                    push;
  logic [xbar_pkg::BANK_IDX_W-1:0]                         push_idx;
  logic                                                    full;

  xbar_req_demux u_req_demux (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .req_i         (req_i),
    .we_i          (we_i),
    .be_i          (be_i),
    .addr_i        (addr_i),
    .wdata_i       (wdata_i),
    .default_idx_i (default_idx_i),
    .gnt_o         (gnt_o),
    .bank_req_o    (bank_req),
    .bank_we_o     (bank_we),
    .bank_be_o     (bank_be),
    .bank_addr_o   (bank_addr),
    .bank_wdata_o  (bank_wdata),
    .bank_gnt_i    (bank_gnt),
    .push_o        (push),
    .push_idx_o    (push_idx),
    .full_i        (full)
  );

  // One bank per region
  for (genvar i = 0; i < xbar_pkg::NUM_BANKS; i++) begin : gen_banks
    obi_sram_bank u_bank (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .req_i    (bank_req[i]),
      .we_i     (bank_we),
      .be_i     (bank_be),
      .addr_i   (bank_addr),
      .wdata_i  (bank_wdata),
      .gnt_o    (bank_gnt[i]),
      .rvalid_o (bank_rvalid[i]),
      .rdata_o  (bank_rdata[i]),
      .take_i   (bank_take[i])
    );
  end

  // In-order return path
  xbar_rsp_collect u_rsp_collect (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .push_i        (push),
    .push_idx_i    (push_idx),
    .full_o        (full),
    .bank_rvalid_i (bank_rvalid),
    .bank_rdata_i  (bank_rdata),
    .bank_take_o   (bank_take),
    .rvalid_o      (rvalid_o),
    .rdata_o       (rdata_o)
  );

endmodule

// ==== logic/xbar_rsp_collect.sv ====
`timescale 1ns/100ps

module xbar_rsp_collect (
  input  logic                                              clk_i,
  input  logic                                              reset_i,
  // Push from the demux, one per grant
  input  logic                                              push_i,
  input  logic [xbar_pkg::BANK_IDX_W-1:0]                   push_idx_i,
  output logic                                              full_o,
  // Bank responses
  input  logic [xbar_pkg::NUM_BANKS-1:0]                    bank_rvalid_i,
  input  logic [xbar_pkg::NUM_BANKS-1:0][xbar_pkg::DATA_W-1:0] bank_rdata_i,
  output logic [xbar_pkg::NUM_BANKS-1:0]                    bank_take_o,
  // Master response
  output logic                                              rvalid_o,
  output logic [xbar_pkg::DATA_W-1:0]                       rdata_o
);

  // Bank index per request in flight, issue order
  logic [xbar_pkg::BANK_IDX_W-1:0]  order_q [xbar_pkg::OUTSTANDING_DEPTH];
  logic [xbar_pkg::QPTR_W-1:0]      wr_ptr_q;
  logic [xbar_pkg::QPTR_W-1:0]      rd_ptr_q;
  logic [xbar_pkg::QCNT_W-1:0]      count_q;

  logic                             empty;
  logic                             pop;
  logic [xbar_pkg::BANK_IDX_W-1:0]  head_idx;

  // --------------------
  // Queue status
  // --------------------
  assign empty    = (count_q == '0);
  assign full_o   = (count_q == xbar_pkg::QCNT_W'(xbar_pkg::OUTSTANDING_DEPTH));
  assign head_idx = order_q[rd_ptr_q];

  // --------------------
  // Head response
  // --------------------
  // Only the oldest request's bank may answer
  // A faster bank further back keeps holding its data
  assign rvalid_o = ~empty & bank_rvalid_i[head_idx];
  assign rdata_o  = bank_rdata_i[head_idx];
  assign pop      = rvalid_o;

  // Release the head bank in the same cycle
  always_comb begin
    bank_take_o           = '0;
    bank_take_o[head_idx] = pop;
  end

  // --------------------
  // Pointers and count
  // --------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // Push and pop together leave the count alone
      case ({push_i, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Entry storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      order_q[wr_ptr_q] <= push_idx_i;
    end
  end

endmodule

// ==== logic/obi_sram_bank.sv ====
`timescale 1ns/100ps

module obi_sram_bank (
  input  logic                              clk_i,
  input  logic                              reset_i,
  // Request from the demux
  input  logic                              req_i,
  input  logic                              we_i,
  input  logic [xbar_pkg::BE_W-1:0]         be_i,
  input  logic [xbar_pkg::ADDR_W-1:0]       addr_i,
  input  logic [xbar_pkg::DATA_W-1:0]       wdata_i,
  output logic                              gnt_o,
  // Response toward the collector
  output logic                              rvalid_o,
  output logic [xbar_pkg::DATA_W-1:0]       rdata_o,
  input  logic                              take_i
);

  xbar_pkg::addr_word_u                     addr_w;
  logic [xbar_pkg::WORD_IDX_W-1:0]          word_idx;
  logic [xbar_pkg::LAT_W-1:0]               extra_lat;

  logic [xbar_pkg::BANK_ST_W-1:0]           state_q;
  logic [xbar_pkg::LAT_W-1:0]               cnt_q;
  logic                                     capture;

  // Storage and response word
  logic [xbar_pkg::DATA_W-1:0]              mem [xbar_pkg::BANK_WORDS];
  logic [xbar_pkg::DATA_W-1:0]              rdata_q;

  assign addr_w.raw = addr_i;
  assign word_idx   = addr_w.fld.word_idx;
  // Latency rule, low word index bits
  assign extra_lat  = word_idx[xbar_pkg::LAT_W-1:0];

  // Accept only from idle
  assign gnt_o   = (state_q == xbar_pkg::ST_IDLE);
  assign capture = req_i & gnt_o;

  // --------------------
  // Controller
  // --------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= xbar_pkg::ST_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        xbar_pkg::ST_IDLE: begin
          if (capture) begin
            cnt_q <= extra_lat;
            // Single-cycle access goes straight to hold
            if (extra_lat == '0) begin
              state_q <= xbar_pkg::ST_HOLD;
            end else begin
              state_q <= xbar_pkg::ST_WAIT;
            end
          end
        end
        xbar_pkg::ST_WAIT: begin
          // Count down the extra cycles
          if (cnt_q == xbar_pkg::LAT_W'(1)) begin
            state_q <= xbar_pkg::ST_HOLD;
          end
          cnt_q <= cnt_q - 1'b1;
        end
        xbar_pkg::ST_HOLD: begin
          // Response sits here until the collector takes it
          if (take_i) begin
            state_q <= xbar_pkg::ST_IDLE;
          end
        end
        default: begin
          state_q <= xbar_pkg::ST_IDLE;
        end
      endcase
    end
  end

  // --------------------
  // Array access
  // --------------------
  // Data is fixed at capture, delay is only in the handshake
  always_ff @(posedge clk_i) begin
    if (capture) begin
      if (we_i) begin
        for (int b = 0; b < xbar_pkg::BE_W; b++) begin
          if (be_i[b]) begin
            mem[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
        // Write ack carries zero
        rdata_q <= '0;
      end else begin
        rdata_q <= mem[word_idx];
      end
    end
  end

  assign rvalid_o = (state_q == xbar_pkg::ST_HOLD);
  assign rdata_o  = rdata_q;

endmodule

// ==== logic/xbar_req_demux.sv ====
`timescale 1ns/100ps

module xbar_req_demux (
  input  logic                                          clk_i,
  input  logic                                          reset_i,
  // Master request side
  input  logic                                          req_i,
  input  logic                                          we_i,
  input  logic [xbar_pkg::BE_W-1:0]                     be_i,
  input  logic [xbar_pkg::ADDR_W-1:0]                   addr_i,
  input  logic [xbar_pkg::DATA_W-1:0]                   wdata_i,
  input  logic [xbar_pkg::BANK_IDX_W-1:0]               default_idx_i,
  output logic                                          gnt_o,
  // Bank request lines, payload shared
  output logic [xbar_pkg::NUM_BANKS-1:0]                bank_req_o,
  output logic                                          bank_we_o,
  output logic [xbar_pkg::BE_W-1:0]                     bank_be_o,
  output logic [xbar_pkg::ADDR_W-1:0]                   bank_addr_o,
  output logic [xbar_pkg::DATA_W-1:0]                   bank_wdata_o,
  input  logic [xbar_pkg::NUM_BANKS-1:0]                bank_gnt_i,
  // Order queue push
  output logic                                          push_o,
  output logic [xbar_pkg::BANK_IDX_W-1:0]               push_idx_o,
  input  logic                                          full_i
);

  xbar_pkg::addr_word_u                  dec_addr;
  logic [xbar_pkg::BANK_IDX_W-1:0]       dec_idx;
  logic [xbar_pkg::BANK_IDX_W-1:0]       sel_idx;
  // Index held while a request waits for its grant
  logic [xbar_pkg::BANK_IDX_W-1:0]       idx_q;
  logic                                  pend_q;
  logic                                  room;

  assign dec_addr.raw = addr_i;

  xbar_addr_decode u_addr_decode (
    .addr_i        (dec_addr),
    .default_idx_i (default_idx_i),
    .idx_o         (dec_idx)
  );

  // --------------------
  // Target selection
  // --------------------
  // Fresh request uses the live decode
  // Stalled request keeps the bank it started with, even if default moves
  assign sel_idx = pend_q ? idx_q : dec_idx;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pend_q <= 1'b0;
      idx_q  <= '0;
    end else begin
      pend_q <= req_i & ~gnt_o;
      idx_q  <= sel_idx;
    end
  end

  // --------------------
  // Grant and steering
  // --------------------
  // Queue must have a free slot for the new entry
  assign room = ~full_i;

  always_comb begin
    bank_req_o          = '0;
    bank_req_o[sel_idx] = req_i & room;
  end

  // Grant follows target bank's idle state
  assign gnt_o = bank_gnt_i[sel_idx] & room;

  // Payload fans out to every bank, only one sees req
  assign bank_we_o    = we_i;
  assign bank_be_o    = be_i;
  assign bank_addr_o  = addr_i;
  assign bank_wdata_o = wdata_i;

  // One queue entry per accepted request
  assign push_o     = req_i & gnt_o;
  assign push_idx_o = sel_idx;

endmodule

// ==== logic/xbar_addr_decode.sv ====
`timescale 1ns/100ps

module xbar_addr_decode (
  // Address as seen on the master port
  input  xbar_pkg::addr_word_u             addr_i,
  // Fallback target for unmapped regions
  input  logic [xbar_pkg::BANK_IDX_W-1:0]  default_idx_i,
  // Selected bank
  output logic [xbar_pkg::BANK_IDX_W-1:0]  idx_o
);

  // Set once a region tag has matched
  logic hit;

  // --------------------
  // Region lookup
  // --------------------
  // Walk the table from bank 0 upwards
  // First match wins, later matches are ignored
  // Nothing matched means the default bank is used
  always_comb begin
    idx_o = default_idx_i;
    hit   = 1'b0;
    for (int i = 0; i < xbar_pkg::NUM_BANKS; i++) begin
      // Only the upper 20 bits take part in the compare
      if (!hit && (addr_i.fld.region == xbar_pkg::BANK_REGION[i])) begin
        idx_o = xbar_pkg::BANK_IDX_W'(i);
        hit   = 1'b1;
      end
    end
  end

  // Notes on the map
  // Regions are 4 KiB each, one per bank
  // Only 1 KiB of every region is backed by storage
  // Word index aliases inside the region (pad bits are ignored)
  // Byte offset is not used for word accesses
  //
  // Unmapped accesses are not reported as errors
  // They simply fall through to default_idx_i
  //
  // Lookup is purely combinational, same cycle as req

endmodule

// ==== logic/xbar_pkg.sv ====
package xbar_pkg;

  // --------------------
  // Bus widths
  // --------------------
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned BE_W   = DATA_W / 8;

  // --------------------
  // Bank geometry
  // --------------------
  localparam int unsigned NUM_BANKS  = 4;
  localparam int unsigned BANK_IDX_W = 2;
  localparam int unsigned BANK_WORDS = 256;
  localparam int unsigned WORD_IDX_W = $clog2(BANK_WORDS);

  // Region tags, bank 0 in the low slot
  localparam int unsigned REGION_W = 20;
  localparam logic [NUM_BANKS-1:0][REGION_W-1:0] BANK_REGION = {
    20'h00013, 20'h00012, 20'h00011, 20'h00010
  };

  // Extra cycles on top of the fixed one, taken from word_idx low bits
  localparam int unsigned MAX_EXTRA_LAT = 3;
  localparam int unsigned LAT_W = $clog2(MAX_EXTRA_LAT + 1);

  // Bank controller encodings
  localparam int unsigned BANK_ST_W = 2;
  localparam logic [BANK_ST_W-1:0] ST_IDLE = 2'd0;
  localparam logic [BANK_ST_W-1:0] ST_WAIT = 2'd1;
  localparam logic [BANK_ST_W-1:0] ST_HOLD = 2'd2;

  // --------------------
  // Order queue
  // --------------------
  localparam int unsigned OUTSTANDING_DEPTH = 4;
  localparam int unsigned QPTR_W = $clog2(OUTSTANDING_DEPTH);
  localparam int unsigned QCNT_W = QPTR_W + 1;

  // Address word, flat or split into fields
  typedef union packed {
    logic [ADDR_W-1:0] raw;
    struct packed {
      logic [REGION_W-1:0]   region;
      logic [1:0]            pad;
      logic [WORD_IDX_W-1:0] word_idx;
      logic [1:0]            byte_off;
    } fld;
  } addr_word_u;

endpackage
